/* filelist.f */
logic/icache_pkg.sv
logic/line_fill_if.sv
logic/icache_tag_store.sv
logic/icache_data_ram.sv
logic/icache_refill.sv
logic/icache_ctrl.sv
logic/icache_top.sv
testbench/tb_mem_model.sv
testbench/tb_icache.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the instruction cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 -Wno-fatal --top-module tb_icache -f filelist.f -o sim_icache

# A fatal stop exits non-zero, the log decides the verdict
./obj_dir/sim_icache > sim.log 2>&1 || true
cat sim.log

if grep -q "Checks failed" sim.log; then
    exit 1
fi
grep -q "All checks passed" sim.log

/* testbench/tb_icache.sv */
//----------------------------------------
// Testbench for icache_top, 16 x 32 words, memory with random stalls
// Stops at the first error, cycle limit guards against a hang
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_icache
    import icache_pkg::*;
();

    localparam int NUM_LINES  = 16;
    localparam int LINE_WORDS = 32;
    localparam int LINE_SH    = $clog2(LINE_WORDS) + 2;  // Byte offset bits of a line
    localparam int N_RAND     = 40;
    localparam logic [ADDR_W-1:0] BASE = 32'h0000_1000;
    // Every read bounded by one burst with 3 stalls per word, then doubled
    localparam int MAX_CYCLES = 2 * (N_RAND + NUM_LINES + 24) * (4 * LINE_WORDS + 16);

    logic              mclk;
    logic              rst_n;
    logic              cpu_req;
    logic [ADDR_W-1:0] cpu_addr;
    rd_width_e         cpu_width;
    logic              cpu_ack;
    logic [DATA_W-1:0] cpu_rdata;
    logic              cpu_rvalid;
    logic              mem_stb;
    logic [ADDR_W-1:0] mem_adr;
    logic [BL_W-1:0]   mem_bl;
    logic [DATA_W-1:0] mem_dat;
    logic              mem_ack;
    logic              mem_lack;
    int                bursts;

    logic [31:0]       lfsr;                 // Stimulus LFSR
    logic [DATA_W-1:0] exp_q[$];             // Expected data, oldest first
    string             name_q[$];
    logic [ADDR_W-1:0] resident[$];          // Line numbers held, oldest first
    logic [ADDR_W-1:0] req_addr   = '0;
    int                cycle      = 0;
    int                accept_cyc = 0;
    int                rvalid_cyc = 0;
    int                done_cnt   = 0;
    logic              stb_q      = 1'b0;

    icache_top #(.NUM_LINES(NUM_LINES), .LINE_WORDS(LINE_WORDS)) dut (
        .mclk, .rst_n,
        .cpu_req_i (cpu_req), .cpu_addr_i (cpu_addr), .cpu_width_i (cpu_width),
        .cpu_ack_o (cpu_ack), .cpu_rdata_o (cpu_rdata), .cpu_rvalid_o (cpu_rvalid),
        .mem_stb_o (mem_stb), .mem_adr_o (mem_adr), .mem_bl_o (mem_bl),
        .mem_dat_i (mem_dat), .mem_ack_i (mem_ack), .mem_lack_i (mem_lack)
    );

    tb_mem_model u_mem (
        .mclk, .rst_n, .mem_stb_i (mem_stb), .mem_adr_i (mem_adr), .mem_bl_i (mem_bl),
        .mem_dat_o (mem_dat), .mem_ack_o (mem_ack), .mem_lack_o (mem_lack),
        .burst_cnt_o (bursts)
    );

    //----------------------------------------
    // Reference model
    //----------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);                // One step per bit
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] ref_word(input logic [31:0] w);
        return (w * 32'h9e37_79b1) ^ w;
    endfunction

    // Lane shifted down and zero-extended
    function automatic logic [31:0] expect_read(input logic [31:0] addr, input rd_width_e width);
        logic [31:0] word;
        word = ref_word(addr >> 2);
        case (width)
            BYTE:    return (word >> (8 * addr[1:0])) & 32'h0000_00ff;
            HALF:    return (word >> (16 * addr[1])) & 32'h0000_ffff;
            default: return word;
        endcase
    endfunction

    // FIFO replacement, a miss pushes the line and drops the oldest
    function automatic bit predict_miss(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] line;
        bit                found;
        line  = addr >> LINE_SH;
        found = 1'b0;
        foreach (resident[i])
            if (resident[i] == line)
                found = 1'b1;
        if (!found) begin
            resident.push_back(line);
            if (resident.size() > NUM_LINES)
                resident.delete(0);
        end
        return !found;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
            stop_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
    endtask

    // One CPU read, data checked by the compare process
    task automatic read_check(input string name, input logic [ADDR_W-1:0] addr,
                              input rd_width_e width);
        bit miss;
        int bursts_before;
        int target;
        miss          = predict_miss(addr);
        bursts_before = bursts;
        target        = done_cnt + 1;
        @(posedge mclk);
        cpu_req   <= 1'b1;
        cpu_addr  <= addr;
        cpu_width <= width;
        req_addr  = addr;
        exp_q.push_back(expect_read(addr, width));
        name_q.push_back(name);
        do @(posedge mclk); while (!cpu_ack);     // Accept edge
        accept_cyc = cycle;
        cpu_req <= 1'b0;
        while (done_cnt != target)
            @(posedge mclk);
        check_val({name, " bursts"}, 32'(miss), 32'(bursts - bursts_before));
        if (!miss)
            check_val({name, " latency"}, 3, rvalid_cyc - accept_cyc - 1);  // Seen one edge late
    endtask

    //----------------------------------------
    // Clock, watchdog, monitors
    //----------------------------------------
    initial begin
        mclk = 1'b0;
        forever #20 mclk = ~mclk;                 // 40 ns period
    end

    always @(posedge mclk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES)
            stop_run("timeout, the cache stopped making progress");
    end

    always @(posedge mclk) begin
        if (cpu_rvalid) begin
            if (exp_q.size() == 0) begin
                stop_run("read data returned with no read outstanding");
            end else begin
                check_val(name_q.pop_front(), exp_q.pop_front(), cpu_rdata);
                rvalid_cyc <= cycle;
                done_cnt   <= done_cnt + 1;
            end
        end
    end

    // Each burst must ask for the whole line of the pending read
    always @(posedge mclk) begin
        stb_q <= mem_stb;
        if (mem_stb && !stb_q) begin
            check_val("burst address", (req_addr >> LINE_SH) << LINE_SH, mem_adr);
            check_val("burst length", LINE_WORDS, 32'(mem_bl));
        end
    end

    //----------------------------------------
    // Tests
    //----------------------------------------
    initial begin
        logic [31:0]       r;
        logic [ADDR_W-1:0] addr;
        rd_width_e         width;
        rst_n     = 1'b0;
        cpu_req   = 1'b0;
        cpu_addr  = '0;
        cpu_width = WORD;
        lfsr      = 32'h64bb;
        repeat (3) begin                          // Reset over four rising edges
            @(negedge mclk);
            check_val("reset rvalid", 0, 32'(cpu_rvalid));
            check_val("reset strobe", 0, 32'(mem_stb));
        end
        @(posedge mclk);
        rst_n <= 1'b1;
        @(negedge mclk);
        check_val("ack after reset", 1, 32'(cpu_ack));

        read_check("first miss", BASE + 32'h24, WORD);
        for (int i = 0; i < 8; i++)
            read_check("line hit", BASE + 32'(16 * i), WORD);
        for (int i = 0; i < 4; i++)
            read_check("byte lane", BASE + 32'h40 + 32'(i), BYTE);
        for (int i = 0; i < 2; i++)
            read_check("half lane", BASE + 32'h48 + 32'(2 * i), HALF);

        // NUM_LINES more lines push out the first one
        for (int i = 1; i <= NUM_LINES; i++)
            read_check("fill line", BASE + 32'(i << LINE_SH), WORD);
        read_check("newest line", BASE + 32'(NUM_LINES << LINE_SH) + 32'h8, WORD);
        read_check("evicted line", BASE + 32'h4, WORD);

        // 32 lines in range, so hits and evictions mix
        for (int n = 0; n < N_RAND; n++) begin
            take_bits(14, r);
            case (r[13:12])
                2'd0:    width = BYTE;
                2'd1:    width = HALF;
                default: width = WORD;
            endcase
            addr = 32'h0002_0000 + {20'd0, r[11:0]};
            if (width == HALF)
                addr[0] = 1'b0;
            if (width == WORD)
                addr[1:0] = 2'b00;
            read_check("random read", addr, width);
        end

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/tb_mem_model.sv */
//----------------------------------------
// Burst memory model, word at word address w is (w * 9e3779b1) ^ w
// 0 to 3 stall cycles before every ack, drawn from a Galois LFSR
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model
    import icache_pkg::*;
(
    input  logic              mclk,
    input  logic              rst_n,
    input  logic              mem_stb_i,
    input  logic [ADDR_W-1:0] mem_adr_i,
    input  logic [BL_W-1:0]   mem_bl_i,
    output logic [DATA_W-1:0] mem_dat_o,
    output logic              mem_ack_o,
    output logic              mem_lack_o,
    output int                burst_cnt_o
);

    logic [31:0]       lfsr_q   = 32'h64bb;
    logic              ack_q    = 1'b0;
    logic              lack_q   = 1'b0;
    logic [DATA_W-1:0] dat_q    = '0;
    logic              active_q = 1'b0;  // Burst in progress
    logic              stb_q    = 1'b0;  // Strobe one edge ago
    logic [29:0]       waddr_q  = '0;    // Next word address
    logic [BL_W-1:0]   left_q   = '0;    // Words still to send
    logic [1:0]        stall_q  = '0;
    int                bursts_q = 0;

    assign mem_dat_o   = dat_q;
    assign mem_ack_o   = ack_q;
    assign mem_lack_o  = lack_q;
    assign burst_cnt_o = bursts_q;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // Taps 32 22 2 1
    endfunction

    function automatic logic [31:0] data_at(input logic [29:0] w);
        return (32'(w) * 32'h9e37_79b1) ^ 32'(w);
    endfunction

    // Two LFSR steps, one per stall bit
    task automatic next_stall(output logic [1:0] cnt);
        for (int i = 0; i < 2; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            cnt[i] = lfsr_q[0];
        end
    endtask

    //----------------------------------------
    // Burst responder
    //----------------------------------------
    always @(posedge mclk or negedge rst_n) begin
        logic [1:0] draw;
        if (!rst_n) begin
            ack_q    <= 1'b0;
            lack_q   <= 1'b0;
            active_q <= 1'b0;
            stb_q    <= 1'b0;
            bursts_q <= 0;
        end else begin
            stb_q <= mem_stb_i;
            if (mem_stb_i && !stb_q)
                bursts_q <= bursts_q + 1;           // Rising strobe
            if (!active_q) begin
                ack_q  <= 1'b0;
                lack_q <= 1'b0;
                if (mem_stb_i && !stb_q) begin
                    next_stall(draw);
                    active_q <= 1'b1;
                    waddr_q  <= mem_adr_i[ADDR_W-1:2];
                    left_q   <= mem_bl_i;
                    stall_q  <= draw;
                end
            end else if (ack_q && lack_q) begin   // Last word taken
                ack_q    <= 1'b0;
                lack_q   <= 1'b0;
                active_q <= 1'b0;
            end else if (stall_q != 2'd0) begin
                ack_q   <= 1'b0;                  // Back-pressure
                stall_q <= stall_q - 2'd1;
            end else begin
                next_stall(draw);
                ack_q   <= 1'b1;
                lack_q  <= (left_q == BL_W'(1));
                dat_q   <= data_at(waddr_q);      // Address order
                waddr_q <= waddr_q + 30'd1;
                left_q  <= left_q - BL_W'(1);
                stall_q <= draw;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/icache_top.sv */
//----------------------------------------
// Read-only instruction cache, NUM_LINES x LINE_WORDS words
// Both sizes must be powers of two, at least 2
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module icache_top
    import icache_pkg::*;
#(
    parameter int NUM_LINES  = 16,
    parameter int LINE_WORDS = 32
) (
    input  logic              mclk,
    input  logic              rst_n,
    // CPU fetch port
    input  logic              cpu_req_i,
    input  logic [ADDR_W-1:0] cpu_addr_i,
    input  rd_width_e         cpu_width_i,
    output logic              cpu_ack_o,
    output logic [DATA_W-1:0] cpu_rdata_o,
    output logic              cpu_rvalid_o,
    // Burst memory bus
    output logic              mem_stb_o,
    output logic [ADDR_W-1:0] mem_adr_o,
    output logic [BL_W-1:0]   mem_bl_o,
    input  logic [DATA_W-1:0] mem_dat_i,
    input  logic              mem_ack_i,
    input  logic              mem_lack_i
);

    localparam int IDX_W = $clog2(NUM_LINES);
    localparam int OFF_W = $clog2(LINE_WORDS);

    logic [ADDR_W-1:0] lookup_addr;
    logic              hit;
    logic [IDX_W-1:0]  hit_idx;
    logic [IDX_W-1:0]  victim_idx;
    logic              rd_en;
    logic [IDX_W-1:0]  rd_line;
    logic [OFF_W-1:0]  rd_word;
    logic [DATA_W-1:0] rd_data;
    logic              refill_req;
    logic [ADDR_W-1:0] refill_addr;
    logic              refill_done;

    line_fill_if #(.NUM_LINES(NUM_LINES), .LINE_WORDS(LINE_WORDS)) fill_bus ();

    icache_ctrl #(.NUM_LINES(NUM_LINES), .LINE_WORDS(LINE_WORDS)) u_ctrl (
        .mclk, .rst_n, .cpu_req_i, .cpu_addr_i, .cpu_width_i,
        .cpu_ack_o, .cpu_rdata_o, .cpu_rvalid_o,
        .lookup_addr_o (lookup_addr), .hit_i (hit), .hit_idx_i (hit_idx),
        .rd_en_o (rd_en), .rd_line_o (rd_line), .rd_word_o (rd_word), .rd_data_i (rd_data),
        .refill_req_o (refill_req), .refill_addr_o (refill_addr), .refill_done_i (refill_done)
    );

    icache_tag_store #(.NUM_LINES(NUM_LINES), .LINE_WORDS(LINE_WORDS)) u_tags (
        .mclk, .rst_n, .fill (fill_bus), .lookup_addr_i (lookup_addr),
        .hit_o (hit), .hit_idx_o (hit_idx), .victim_idx_o (victim_idx)
    );

    icache_data_ram #(.NUM_LINES(NUM_LINES), .LINE_WORDS(LINE_WORDS)) u_ram (
        .mclk, .fill (fill_bus), .rd_en_i (rd_en),
        .rd_line_i (rd_line), .rd_word_i (rd_word), .rd_data_o (rd_data)
    );

    icache_refill #(.NUM_LINES(NUM_LINES), .LINE_WORDS(LINE_WORDS)) u_refill (
        .mclk, .rst_n, .refill_req_i (refill_req), .refill_addr_i (refill_addr),
        .victim_idx_i (victim_idx), .refill_done_o (refill_done), .fill (fill_bus),
        .mem_stb_o, .mem_adr_o, .mem_bl_o, .mem_dat_i, .mem_ack_i, .mem_lack_i
    );

endmodule

`default_nettype wire

/* logic/icache_ctrl.sv */
//----------------------------------------
// CPU side FSM, one read in flight
// Hit returns cpu_rvalid_o three edges after acceptance
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl
    import icache_pkg::*;
#(
    parameter int NUM_LINES  = 16,
    parameter int LINE_WORDS = 32
) (
    input  logic                          mclk,
    input  logic                          rst_n,
    input  logic                          cpu_req_i,
    input  logic [ADDR_W-1:0]             cpu_addr_i,
    input  rd_width_e                     cpu_width_i,
    output logic                          cpu_ack_o,
    output logic [DATA_W-1:0]             cpu_rdata_o,
    output logic                          cpu_rvalid_o,
    output logic [ADDR_W-1:0]             lookup_addr_o,
    input  logic                          hit_i,
    input  logic [$clog2(NUM_LINES)-1:0]  hit_idx_i,
    output logic                          rd_en_o,
    output logic [$clog2(NUM_LINES)-1:0]  rd_line_o,
    output logic [$clog2(LINE_WORDS)-1:0] rd_word_o,
    input  logic [DATA_W-1:0]             rd_data_i,
    output logic                          refill_req_o,
    output logic [ADDR_W-1:0]             refill_addr_o,
    input  logic                          refill_done_i
);

    localparam int OFF_W = $clog2(LINE_WORDS);

    typedef enum logic [1:0] {S_IDLE, S_COMPARE, S_READ, S_REFILL} ctrl_state_e;

    ctrl_state_e       state_q;
    logic [ADDR_W-1:0] addr_q;     // Latched request
    rd_width_e         width_q;
    logic              rd_pend_q;  // RAM data lands next cycle

    assign cpu_ack_o     = (state_q == S_IDLE);
    assign lookup_addr_o = addr_q;
    assign refill_addr_o = addr_q;

    // Tags are stable during S_READ so the hit index still holds
    assign rd_en_o   = (state_q == S_READ);
    assign rd_line_o = hit_idx_i;
    assign rd_word_o = addr_q[OFF_W+1:2];

    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= S_IDLE;
            refill_req_o <= 1'b0;
            rd_pend_q    <= 1'b0;
            cpu_rvalid_o <= 1'b0;
        end else begin
            refill_req_o <= 1'b0;       // Single cycle pulse
            rd_pend_q    <= (state_q == S_READ);
            cpu_rvalid_o <= rd_pend_q;
            case (state_q)
                S_IDLE:    if (cpu_req_i) state_q <= S_COMPARE;
                S_COMPARE: if (hit_i) begin
                    state_q <= S_READ;
                end else begin
                    refill_req_o <= 1'b1;  // Miss, fetch the line
                    state_q      <= S_REFILL;
                end
                S_READ:    state_q <= S_IDLE;
                default:   if (refill_done_i) state_q <= S_COMPARE;  // Retry as hit
            endcase
        end
    end

    // Request and result registers
    always_ff @(posedge mclk) begin
        if (cpu_req_i && cpu_ack_o) begin
            addr_q  <= cpu_addr_i;
            width_q <= cpu_width_i;
        end
        if (rd_pend_q)
            cpu_rdata_o <= extract_lane(width_q, addr_q[1:0], rd_data_i);
    end

endmodule

`default_nettype wire

/* logic/icache_refill.sv */
//----------------------------------------
// Line refill over the burst bus
// mem_lack_i is expected together with the final mem_ack_i
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module icache_refill
    import icache_pkg::*;
#(
    parameter int NUM_LINES  = 16,
    parameter int LINE_WORDS = 32
) (
    input  logic                         mclk,
    input  logic                         rst_n,
    input  logic                         refill_req_i,
    input  logic [ADDR_W-1:0]            refill_addr_i,
    input  logic [$clog2(NUM_LINES)-1:0] victim_idx_i,
    output logic                         refill_done_o,
    line_fill_if.source                  fill,
    output logic                         mem_stb_o,
    output logic [ADDR_W-1:0]            mem_adr_o,
    output logic [BL_W-1:0]              mem_bl_o,
    input  logic [DATA_W-1:0]            mem_dat_i,
    input  logic                         mem_ack_i,
    input  logic                         mem_lack_i
);

    localparam int IDX_W = $clog2(NUM_LINES);
    localparam int OFF_W = $clog2(LINE_WORDS);
    localparam int TAG_W = ADDR_W - OFF_W - 2;

    typedef enum logic [1:0] {R_IDLE, R_BURST, R_TAG, R_DONE} refill_state_e;

    refill_state_e    state_q;
    logic [IDX_W-1:0] victim_q;  // Slot being filled
    logic [TAG_W-1:0] tag_q;
    logic [OFF_W-1:0] word_q;    // Acked word count

    assign mem_bl_o = BL_W'(LINE_WORDS);  // Always a whole line

    // Fill port, one write per ack
    assign fill.fill_we     = (state_q == R_BURST) && mem_ack_i;
    assign fill.fill_line   = victim_q;
    assign fill.fill_word   = word_q;
    assign fill.fill_data   = mem_dat_i;
    assign fill.fill_tag_we = (state_q == R_TAG);
    assign fill.fill_tag    = tag_q;
    assign refill_done_o    = (state_q == R_DONE);

    //----------------------------------------
    // Burst sequencing
    //----------------------------------------
    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= R_IDLE;
            mem_stb_o <= 1'b0;
            word_q    <= '0;
        end else begin
            case (state_q)
                R_IDLE: if (refill_req_i) begin
                    mem_stb_o <= 1'b1;
                    word_q    <= '0;
                    state_q   <= R_BURST;
                end
                R_BURST: if (mem_ack_i) begin
                    word_q <= word_q + 1'b1;  // Address order
                    if (mem_lack_i) begin
                        mem_stb_o <= 1'b0;
                        state_q   <= R_TAG;
                    end
                end
                R_TAG:   state_q <= R_DONE;   // Tag written this cycle
                default: state_q <= R_IDLE;   // R_DONE
            endcase
        end
    end

    // Request capture
    always_ff @(posedge mclk) begin
        if ((state_q == R_IDLE) && refill_req_i) begin
            victim_q  <= victim_idx_i;
            tag_q     <= refill_addr_i[ADDR_W-1 -: TAG_W];
            mem_adr_o <= {refill_addr_i[ADDR_W-1:OFF_W+2], {(OFF_W+2){1'b0}}};  // Line aligned
        end
    end

endmodule

`default_nettype wire

/* logic/icache_data_ram.sv */
//----------------------------------------
// Line by word data array, registered read
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module icache_data_ram
    import icache_pkg::*;
#(
    parameter int NUM_LINES  = 16,
    parameter int LINE_WORDS = 32
) (
    input  logic                          mclk,
    line_fill_if.sink                     fill,
    input  logic                          rd_en_i,
    input  logic [$clog2(NUM_LINES)-1:0]  rd_line_i,
    input  logic [$clog2(LINE_WORDS)-1:0] rd_word_i,
    output logic [DATA_W-1:0]             rd_data_o
);

    logic [DATA_W-1:0] mem_q [NUM_LINES][LINE_WORDS];

    // Write port, refill side
    always_ff @(posedge mclk) begin
        if (fill.fill_we)
            mem_q[fill.fill_line][fill.fill_word] <= fill.fill_data;
    end

    // Read port, one cycle latency
    always_ff @(posedge mclk) begin
        if (rd_en_i)
            rd_data_o <= mem_q[rd_line_i][rd_word_i];  // Holds last value otherwise
    end

endmodule

`default_nettype wire

/* logic/icache_tag_store.sv */
//----------------------------------------
// Fully associative tags with FIFO replacement
// NUM_LINES must be a power of two, at least 2
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module icache_tag_store
    import icache_pkg::*;
#(
    parameter int NUM_LINES  = 16,
    parameter int LINE_WORDS = 32
) (
    input  logic                         mclk,
    input  logic                         rst_n,
    line_fill_if.sink                    fill,
    input  logic [ADDR_W-1:0]            lookup_addr_i,
    output logic                         hit_o,
    output logic [$clog2(NUM_LINES)-1:0] hit_idx_o,
    output logic [$clog2(NUM_LINES)-1:0] victim_idx_o
);

    localparam int IDX_W = $clog2(NUM_LINES);
    localparam int OFF_W = $clog2(LINE_WORDS);
    localparam int TAG_W = ADDR_W - OFF_W - 2;

    logic [TAG_W-1:0]     tag_q [NUM_LINES];
    logic [NUM_LINES-1:0] valid_q;
    logic [IDX_W-1:0]     victim_q;            // Oldest line, next to go
    logic [TAG_W-1:0]     lookup_tag;

    assign lookup_tag   = lookup_addr_i[ADDR_W-1 -: TAG_W];
    assign victim_idx_o = victim_q;

    //----------------------------------------
    // Parallel compare
    //----------------------------------------
    always_comb begin
        hit_o     = 1'b0;
        hit_idx_o = '0;
        for (int i = 0; i < NUM_LINES; i++) begin
            if (valid_q[i] && (tag_q[i] == lookup_tag)) begin
                hit_o     = 1'b1;
                hit_idx_o = IDX_W'(i);  // At most one entry matches
            end
        end
    end

    // Valid bits and replacement pointer
    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q  <= '0;
            victim_q <= '0;
        end else if (fill.fill_tag_we) begin
            valid_q[fill.fill_line] <= 1'b1;
            if (victim_q == IDX_W'(NUM_LINES - 1))
                victim_q <= '0;                   // Wrap to first slot
            else
                victim_q <= victim_q + 1'b1;
        end
    end

    always_ff @(posedge mclk) begin
        if (fill.fill_tag_we)
            tag_q[fill.fill_line] <= fill.fill_tag;
    end

endmodule

`default_nettype wire

/* logic/line_fill_if.sv */
//----------------------------------------
// Refill write path into tag store and data RAM
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface line_fill_if
    import icache_pkg::*;
#(
    parameter int NUM_LINES  = 16,
    parameter int LINE_WORDS = 32
) ();

    localparam int IDX_W = $clog2(NUM_LINES);
    localparam int OFF_W = $clog2(LINE_WORDS);
    localparam int TAG_W = ADDR_W - OFF_W - 2;

    logic              fill_we;      // Word write strobe
    logic [IDX_W-1:0]  fill_line;    // Victim line
    logic [OFF_W-1:0]  fill_word;    // Word within line
    logic [DATA_W-1:0] fill_data;
    logic              fill_tag_we;  // Tag update after last word
    logic [TAG_W-1:0]  fill_tag;

    modport source (output fill_we, fill_line, fill_word, fill_data, fill_tag_we, fill_tag);
    modport sink   (input  fill_we, fill_line, fill_word, fill_data, fill_tag_we, fill_tag);

endinterface

`default_nettype wire

/* logic/icache_pkg.sv */
//----------------------------------------
// Common widths and read helpers for the instruction cache
// Width encoding follows the CPU fetch port, 00 byte, 01 half, 10 word
//----------------------------------------
`default_nettype none

package icache_pkg;

    localparam int ADDR_W = 32;  // CPU and bus byte address
    localparam int DATA_W = 32;  // One cache word
    localparam int BL_W   = 10;  // Burst length field on the bus

    // Access size of a CPU read
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } rd_width_e;

    //----------------------------------------
    // Lane select
    //----------------------------------------
    // Picks the addressed byte or half-word out of a word and zero-extends it
    function automatic logic [DATA_W-1:0] extract_lane(
        input rd_width_e         width,
        input logic [1:0]        lane,
        input logic [DATA_W-1:0] word
    );
        logic [DATA_W-1:0] res;
        case (width)
            BYTE:    res = DATA_W'(word[8*lane +: 8]);
            HALF:    res = DATA_W'(word[16*lane[1] +: 16]);  // lane[0] ignored
            default: res = word;                               // Full word
        endcase
        return res;
    endfunction

endpackage

`default_nettype wire
